//--- rtl/cic_decimator.sv
/*
 * Single channel third-order CIC decimator
 * Integrates the +/-1 bitstream on each strobe, combs every SD_DECIMATION
 * strobes, scales and clamps the sample and offers it to the arbiter
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module cic_decimator #(
    parameter int CHANNEL = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_strobe,
    input  logic                     bit_in,
    input  sd_cfg_pkg::ch_settings_t settings,
    input  logic                     res_ack,
    output logic                     res_req,
    output sd_stream_pkg::sd_result_t res_data,
    output logic                     overrun
);

    localparam int ACC_W = `SD_ACC_W;
    localparam int DEC_W = $clog2(`SD_DECIMATION);

    logic signed [ACC_W-1:0] step;
    logic signed [ACC_W-1:0] integ1, integ2, integ3;
    logic signed [ACC_W-1:0] delay1, delay2, delay3;
    logic signed [ACC_W-1:0] comb1, comb2, comb3;
    logic signed [ACC_W-1:0] scaled, clamped;
    logic [DEC_W-1:0]        dec_cnt;
    logic                    new_result;

    sd_stream_pkg::buf_state_e buf_state;

    // A one on the bitstream weighs +1, a zero weighs -1
    assign step = bit_in ? {{(ACC_W - 1){1'b0}}, 1'b1} : {ACC_W{1'b1}};

    assign new_result = sample_strobe && (dec_cnt == DEC_W'(`SD_DECIMATION - 1));

    // Integrators wrap freely, modular arithmetic keeps the comb output exact
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            integ1  <= '0;
            integ2  <= '0;
            integ3  <= '0;
            dec_cnt <= '0;
        end else if (sample_strobe) begin
            integ1  <= integ1 + step;
            integ2  <= integ2 + integ1;
            integ3  <= integ3 + integ2;
            dec_cnt <= dec_cnt + 1'b1;
        end
    end

    // Comb section runs at the decimated rate
    assign comb1 = integ3 - delay1;
    assign comb2 = comb1 - delay2;
    assign comb3 = comb2 - delay3;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            delay1 <= '0;
            delay2 <= '0;
            delay3 <= '0;
        end else if (new_result) begin
            delay1 <= integ3;
            delay2 <= comb1;
            delay3 <= comb2;
        end
    end

    always_comb begin
        scaled = comb3 >>> settings.shift;
        if (scaled < settings.limit_lo) begin
            clamped = settings.limit_lo;
        end else if (scaled > settings.limit_hi) begin
            clamped = settings.limit_hi;
        end else begin
            clamped = scaled;
        end
    end

    // Result buffer, a new sample is lost if the previous one is still pending
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_state <= sd_stream_pkg::EMPTY;
            overrun   <= 1'b0;
        end else begin
            case (buf_state)
                sd_stream_pkg::EMPTY: begin
                    if (new_result) buf_state <= sd_stream_pkg::REQ;
                end
                sd_stream_pkg::REQ: begin
                    if (res_ack) buf_state <= sd_stream_pkg::WAIT_DROP;
                end
                sd_stream_pkg::WAIT_DROP: begin
                    if (!res_ack) begin
                        buf_state <= new_result ? sd_stream_pkg::REQ : sd_stream_pkg::EMPTY;
                    end
                end
                default: buf_state <= sd_stream_pkg::EMPTY;
            endcase
            if (new_result && (buf_state == sd_stream_pkg::REQ ||
                               (buf_state == sd_stream_pkg::WAIT_DROP && res_ack))) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_result && (buf_state == sd_stream_pkg::EMPTY ||
                           (buf_state == sd_stream_pkg::WAIT_DROP && !res_ack))) begin
            res_data.channel <= `SD_CH_W'(CHANNEL);
            res_data.sample  <= clamped[`SD_DATA_W-1:0];
        end
    end

    assign res_req = (buf_state == sd_stream_pkg::REQ);

    // Arbiter may sample the data in any cycle of the request
    res_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_req && $past(res_req)) |-> $stable(res_data)
    );

endmodule

//--- rtl/result_arbiter.sv
/*
 * Round-robin result arbiter
 * Takes one result at a time from the decimators over four-phase req/ack
 * and presents it on the shared valid/ready output stream
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module result_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`SD_N_CHANNELS-1:0] res_req,
    input  sd_stream_pkg::sd_result_t res_data [`SD_N_CHANNELS],
    output logic [`SD_N_CHANNELS-1:0] res_ack,
    output logic                      out_valid,
    input  logic                      out_ready,
    output sd_stream_pkg::sd_result_t out_data
);

    sd_stream_pkg::arb_state_e state;
    logic [`SD_CH_W-1:0]       grant;
    logic [`SD_CH_W-1:0]       pick;
    logic                      load;

    // Search starts just after the channel granted last
    always_comb begin
        int idx;
        pick = grant;
        for (int k = `SD_N_CHANNELS; k >= 1; k--) begin
            idx = (int'(grant) + k) % `SD_N_CHANNELS;
            if (res_req[idx]) pick = idx[`SD_CH_W-1:0];
        end
    end

    // Output register is free when empty or being taken this cycle
    assign load = (state == sd_stream_pkg::IDLE) && (|res_req) &&
                  (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= sd_stream_pkg::IDLE;
            res_ack   <= '0;
            out_valid <= 1'b0;
            grant     <= `SD_CH_W'(`SD_N_CHANNELS - 1);
        end else begin
            if (out_valid && out_ready) out_valid <= 1'b0;
            case (state)
                sd_stream_pkg::IDLE: begin
                    if (load) begin
                        out_valid      <= 1'b1;
                        res_ack[pick]  <= 1'b1;
                        grant          <= pick;
                        state          <= sd_stream_pkg::SEND;
                    end
                end
                sd_stream_pkg::SEND: begin
                    if (!res_req[grant]) begin
                        res_ack[grant] <= 1'b0;
                        state          <= sd_stream_pkg::RELEASE;
                    end
                end
                default: state <= sd_stream_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) out_data <= res_data[pick];
    end

    one_ack_at_most: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(res_ack)
    );

endmodule

//--- rtl/sd_cfg_pkg.sv
/*
 * Configuration types for the sigma-delta demodulator
 * Register map, the write word of the req/ack port and per-channel settings
 */
`include "sd_macros.svh"

package sd_cfg_pkg;

    // Register bank bases, channel n sits at base + 4n
    typedef enum logic [7:0] {
        SHIFT_BASE    = 8'h00,
        LIMIT_LO_BASE = 8'h10,
        LIMIT_HI_BASE = 8'h20
    } cfg_addr_e;

    // One configuration write as presented by the master
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } cfg_write_t;

    // Scaling and clamping applied to one channel's samples
    typedef struct packed {
        logic [3:0]                   shift;
        logic signed [`SD_DATA_W-1:0] limit_lo;
        logic signed [`SD_DATA_W-1:0] limit_hi;
    } ch_settings_t;

endpackage

//--- rtl/sd_cfg_regs.sv
/*
 * Configuration register target
 * Four-phase req/ack write port holding the shift and clamp limits of
 * every channel, unmapped addresses are acknowledged and dropped
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_cfg_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_req,
    input  sd_cfg_pkg::cfg_write_t   cfg_write,
    output logic                     cfg_ack,
    output sd_cfg_pkg::ch_settings_t settings [`SD_N_CHANNELS]
);

    sd_cfg_pkg::cfg_addr_e field;
    logic [`SD_CH_W-1:0]   ch_idx;
    logic                  addr_aligned;
    logic                  do_write;

    // Upper nibble selects the register bank, word index selects the channel
    assign field    = sd_cfg_pkg::cfg_addr_e'({cfg_write.addr[7:4], 4'h0});
    assign ch_idx   = cfg_write.addr[2 +: `SD_CH_W];

    // Registers sit on word boundaries, byte offsets inside a word are unmapped
    assign addr_aligned = (cfg_write.addr[1:0] == 2'b00);

    // A request is served only in the cycle before the ack goes up
    assign do_write = cfg_req && !cfg_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_ack <= 1'b0;
        end else if (do_write) begin
            cfg_ack <= 1'b1;
        end else if (!cfg_req && cfg_ack) begin
            cfg_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SD_N_CHANNELS; i++) begin
                settings[i].shift    <= '0;
                settings[i].limit_lo <= {1'b1, {(`SD_DATA_W - 1){1'b0}}};
                settings[i].limit_hi <= {1'b0, {(`SD_DATA_W - 1){1'b1}}};
            end
        end else if (do_write && addr_aligned) begin
            case (field)
                sd_cfg_pkg::SHIFT_BASE: begin
                    settings[ch_idx].shift <= cfg_write.data[3:0];
                end
                sd_cfg_pkg::LIMIT_LO_BASE: begin
                    settings[ch_idx].limit_lo <= cfg_write.data[`SD_DATA_W-1:0];
                end
                sd_cfg_pkg::LIMIT_HI_BASE: begin
                    settings[ch_idx].limit_hi <= cfg_write.data[`SD_DATA_W-1:0];
                end
                default: begin
                    // Outside the register map, nothing to update
                end
            endcase
        end
    end

    // The master must keep the write word steady until it has seen the ack
    cfg_write_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cfg_req && !cfg_ack) |=> $stable(cfg_write)
    );

endmodule

//--- rtl/sd_clock_gen.sv
/*
 * Modulator clock generator
 * Divides clk by SD_CLK_DIV into a 50% duty sd_clk and a one-cycle
 * sample strobe that coincides with each rising edge of sd_clk
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_clock_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic sd_clk,
    output logic sample_strobe
);

    localparam int CNT_W = $clog2(`SD_CLK_DIV);

    logic [CNT_W-1:0] div_cnt;

    // sd_clk is high for the first half of each count period
    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            div_cnt       <= '0;
            sd_clk        <= 1'b0;
            sample_strobe <= 1'b0;
        end else begin
            if (div_cnt == CNT_W'(`SD_CLK_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            sd_clk        <= (div_cnt < CNT_W'(`SD_CLK_DIV / 2));
            sample_strobe <= (div_cnt == '0);
        end
    end

    // Decimators count strobes, so a stretched strobe would double count a bit
    strobe_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_strobe |=> !sample_strobe
    );

endmodule

//--- rtl/sd_macros.svh
/*
 * Sigma-delta demodulator build constants
 * Channel count, CIC decimation ratio, modulator clock divider and widths
 */
`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// Number of modulator bitstreams handled in parallel
`define SD_N_CHANNELS 4

// CIC decimation ratio R, counted in modulator clock strobes
`define SD_DECIMATION 16

// CIC filter order N, fixed by the three integrator and comb stages in the RTL
`define SD_CIC_ORDER 3

// clk cycles per modulator clock period
`define SD_CLK_DIV 4

// Signed output sample width and CIC accumulator width
`define SD_DATA_W 16
`define SD_ACC_W 16

// Width of the channel tag carried with every result
`define SD_CH_W 2

`endif

//--- rtl/sd_stream_pkg.sv
/*
 * Data path types for the sigma-delta demodulator
 * Tagged result word and the handshake state machines of decimator and arbiter
 */
`include "sd_macros.svh"

package sd_stream_pkg;

    // A filtered sample together with the channel that produced it
    typedef struct packed {
        logic [`SD_CH_W-1:0]          channel;
        logic signed [`SD_DATA_W-1:0] sample;
    } sd_result_t;

    // One-entry result buffer inside each decimator
    typedef enum logic [1:0] {
        EMPTY,
        REQ,
        WAIT_DROP
    } buf_state_e;

    // Arbiter sequencing of one four-phase exchange
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        RELEASE
    } arb_state_e;

endpackage

//--- rtl/sigma_delta_top.sv
/*
 * Multichannel sigma-delta demodulator
 * Clock generator, configuration registers, one CIC decimator per channel
 * and the arbiter that merges their results onto one tagged output stream
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module sigma_delta_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [`SD_N_CHANNELS-1:0] bits_in,
    output logic                      sd_clk,
    input  logic                      cfg_req,
    input  sd_cfg_pkg::cfg_write_t    cfg_write,
    output logic                      cfg_ack,
    output logic                      out_valid,
    input  logic                      out_ready,
    output sd_stream_pkg::sd_result_t out_data,
    output logic                      overrun
);

    logic                      sample_strobe;
    sd_cfg_pkg::ch_settings_t  settings [`SD_N_CHANNELS];
    logic [`SD_N_CHANNELS-1:0] res_req;
    logic [`SD_N_CHANNELS-1:0] res_ack;
    logic [`SD_N_CHANNELS-1:0] ch_overrun;
    sd_stream_pkg::sd_result_t res_data [`SD_N_CHANNELS];

    sd_clock_gen u_clock_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .sd_clk        (sd_clk),
        .sample_strobe (sample_strobe)
    );

    sd_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_req   (cfg_req),
        .cfg_write (cfg_write),
        .cfg_ack   (cfg_ack),
        .settings  (settings)
    );

    for (genvar ch = 0; ch < `SD_N_CHANNELS; ch++) begin : g_channel
        cic_decimator #(
            .CHANNEL (ch)
        ) u_decimator (
            .clk           (clk),
            .rst_n         (rst_n),
            .sample_strobe (sample_strobe),
            .bit_in        (bits_in[ch]),
            .settings      (settings[ch]),
            .res_ack       (res_ack[ch]),
            .res_req       (res_req[ch]),
            .res_data      (res_data[ch]),
            .overrun       (ch_overrun[ch])
        );
    end

    result_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_req   (res_req),
        .res_data  (res_data),
        .res_ack   (res_ack),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // Any channel that lost a result raises the shared flag
    assign overrun = |ch_overrun;

endmodule

//--- sim.f
+incdir+rtl
+incdir+tests
rtl/sd_cfg_pkg.sv
rtl/sd_stream_pkg.sv
rtl/sd_clock_gen.sv
rtl/sd_cfg_regs.sv
rtl/cic_decimator.sv
rtl/result_arbiter.sv
rtl/sigma_delta_top.sv
tests/sigma_delta_tb.sv

//--- tests/sd_check_tasks.svh
/*
 * Compare tasks for the sigma-delta demodulator testbench
 * One task per kind of DUT result, each with its own check and error count
 */
`ifndef SD_CHECK_TASKS_SVH
`define SD_CHECK_TASKS_SVH

int result_checks = 0;
int result_errors = 0;
int flag_checks   = 0;
int flag_errors   = 0;

// Output stream words are compared field by field
task automatic check_result(input string                     name,
                            input sd_stream_pkg::sd_result_t got,
                            input sd_stream_pkg::sd_result_t exp);
    result_checks++;
    if (got.channel !== exp.channel || got.sample !== exp.sample) begin
        result_errors++;
        $display("[FAIL] %s channel got 0x%h expected 0x%h, sample got 0x%h expected 0x%h",
                 name, got.channel, exp.channel, got.sample, exp.sample);
    end
endtask

// Single-bit status outputs such as overrun, out_valid and cfg_ack
task automatic check_flag(input string name,
                          input logic  got,
                          input logic  exp);
    flag_checks++;
    if (got !== exp) begin
        flag_errors++;
        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
endtask

`endif

//--- tests/sigma_delta_tb.sv
/*
 * Testbench for the multichannel sigma-delta demodulator
 * Writes channel settings over the req/ack port, drives constant and
 * alternating bitstreams from a table and checks the settled CIC results
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module sigma_delta_tb;

    localparam int         n_ch       = `SD_N_CHANNELS;
    localparam int         n_rows     = 4;
    localparam int         n_skip     = 3;
    localparam int         n_check    = 2;
    localparam int         lim_min    = -32768;
    localparam int         lim_max    = 32767;
    localparam logic [1:0] kind_ones  = 2'd0;
    localparam logic [1:0] kind_zeros = 2'd1;
    localparam logic [1:0] kind_alt   = 2'd2;

    // One table entry per channel, bit pattern plus register contents
    typedef struct packed {
        logic [1:0]               kind;
        sd_cfg_pkg::ch_settings_t cfg;
    } ch_stim_t;

    logic                      clk;
    logic                      rst_n;
    logic                      enable;
    logic [n_ch-1:0]           bits_in;
    logic                      sd_clk;
    logic                      cfg_req;
    sd_cfg_pkg::cfg_write_t    cfg_write;
    logic                      cfg_ack;
    logic                      out_valid;
    logic                      out_ready;
    sd_stream_pkg::sd_result_t out_data;
    logic                      overrun;

    ch_stim_t                  rows [n_rows][n_ch];
    logic                      row_random [n_rows];
    sd_stream_pkg::sd_result_t exp_res [n_ch];
    logic [1:0]                cur_kind [n_ch];
    int                        seen [n_ch];
    int                        next_ch;
    logic                      collecting;
    int                        ready_mode;
    integer                    seed;
    logic                      sd_clk_q;
    logic                      alt_phase;
    logic [3:0]                strobe_cnt;
    int                        timeout_errors = 0;

    `include "sd_check_tasks.svh"

    sigma_delta_top u_sigma_delta_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .bits_in   (bits_in),
        .sd_clk    (sd_clk),
        .cfg_req   (cfg_req),
        .cfg_write (cfg_write),
        .cfg_ack   (cfg_ack),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .overrun   (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic ch_stim_t stim(input logic [1:0] kind, input int shift,
                                      input int lo, input int hi);
        ch_stim_t s;
        s.kind         = kind;
        s.cfg.shift    = shift[3:0];
        s.cfg.limit_lo = lo[`SD_DATA_W-1:0];
        s.cfg.limit_hi = hi[`SD_DATA_W-1:0];
        return s;
    endfunction

    // Settled CIC gain is R^N, then the shift and the clamp apply
    function automatic logic signed [`SD_DATA_W-1:0] expected_sample(input ch_stim_t s);
        int clean;
        int v;
        clean = `SD_DECIMATION ** `SD_CIC_ORDER;
        case (s.kind)
            kind_ones:  v = clean;
            kind_zeros: v = -clean;
            default:    v = 0;
        endcase
        v = v >>> s.cfg.shift;
        if (v < int'(s.cfg.limit_lo)) begin
            v = s.cfg.limit_lo;
        end else if (v > int'(s.cfg.limit_hi)) begin
            v = s.cfg.limit_hi;
        end
        return v[`SD_DATA_W-1:0];
    endfunction

    function automatic logic pattern_bit(input logic [1:0] kind, input logic phase);
        case (kind)
            kind_ones:  return 1'b1;
            kind_zeros: return 1'b0;
            default:    return phase;
        endcase
    endfunction

    task automatic end_run();
        $display("Checks %0d results %0d flags, errors %0d result %0d flag %0d timeout",
                 result_checks, flag_checks, result_errors, flag_errors, timeout_errors);
        if (result_errors + flag_errors + timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // A rise of sd_clk marks the cycle in which the DUT samples bits_in
    always @(posedge clk) begin
        if (!rst_n) begin
            sd_clk_q   <= 1'b0;
            alt_phase  <= 1'b0;
            strobe_cnt <= '0;
        end else begin
            sd_clk_q <= sd_clk;
            if (sd_clk && !sd_clk_q) begin
                strobe_cnt <= strobe_cnt + 1'b1;
                alt_phase  <= !alt_phase;
                for (int ch = 0; ch < n_ch; ch++) begin
                    bits_in[ch] <= pattern_bit(cur_kind[ch], alt_phase);
                end
            end
        end
    end

    always @(posedge clk) begin
        case (ready_mode)
            0:       out_ready <= 1'b1;
            1:       out_ready <= ($random(seed) % 4) != 0;
            default: out_ready <= 1'b0;
        endcase
    end

    // All decimators finish together, so the round-robin arbiter
    // hands their results out in channel order
    always @(posedge clk) begin : collect_results
        if (rst_n && collecting && out_valid && out_ready) begin
            if (seen[next_ch] >= n_skip && seen[next_ch] < n_skip + n_check) begin
                check_result("out_data", out_data, exp_res[next_ch]);
            end
            seen[next_ch] <= seen[next_ch] + 1;
            next_ch       <= (next_ch + 1) % n_ch;
        end
    end

    task automatic write_cfg(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        cfg_write.addr <= addr;
        cfg_write.data <= data;
        cfg_req        <= 1'b1;
        n = 0;
        while (cfg_ack !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                $display("Timeout waiting for cfg_ack to rise at address 0x%h", addr);
                timeout_errors++;
                end_run();
            end
        end
        cfg_req <= 1'b0;
        n = 0;
        while (cfg_ack !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                $display("Timeout waiting for cfg_ack to fall at address 0x%h", addr);
                timeout_errors++;
                end_run();
            end
        end
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("overrun", overrun, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("cfg_ack", cfg_ack, 1'b0);
        check_flag("sd_clk", sd_clk, 1'b0);
    endtask

    // Halfway through a decimation period no result is in flight
    task automatic wait_mid_period();
        int n;
        n = 0;
        while (strobe_cnt != 4'd8) begin
            @(posedge clk);
            n++;
            if (n > 200) begin
                $display("Timeout waiting for the middle of a decimation period");
                timeout_errors++;
                end_run();
            end
        end
    endtask

    task automatic wait_results();
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            n++;
            done = 1'b1;
            for (int ch = 0; ch < n_ch; ch++) begin
                if (seen[ch] < n_skip + n_check) done = 1'b0;
            end
            if (!done && n > 1000) begin
                $display("Timeout waiting for results on every channel");
                timeout_errors++;
                end_run();
            end
        end
    endtask

    task automatic run_row(input int r);
        for (int ch = 0; ch < n_ch; ch++) begin
            write_cfg(8'(sd_cfg_pkg::SHIFT_BASE) + 8'(4 * ch), 32'(rows[r][ch].cfg.shift));
            write_cfg(8'(sd_cfg_pkg::LIMIT_LO_BASE) + 8'(4 * ch),
                      {{16{rows[r][ch].cfg.limit_lo[15]}}, rows[r][ch].cfg.limit_lo});
            write_cfg(8'(sd_cfg_pkg::LIMIT_HI_BASE) + 8'(4 * ch),
                      {{16{rows[r][ch].cfg.limit_hi[15]}}, rows[r][ch].cfg.limit_hi});
            exp_res[ch].channel = ch[`SD_CH_W-1:0];
            exp_res[ch].sample  = expected_sample(rows[r][ch]);
        end
        wait_mid_period();
        for (int ch = 0; ch < n_ch; ch++) begin
            cur_kind[ch] <= rows[r][ch].kind;
            seen[ch]     <= 0;
        end
        next_ch    <= 0;
        ready_mode <= row_random[r] ? 1 : 0;
        collecting <= 1'b1;
        wait_results();
        collecting <= 1'b0;
        ready_mode <= 0;
        check_flag("overrun", overrun, 1'b0);
    endtask

    initial begin
        rst_n      = 1'b0;
        enable     = 1'b1;
        bits_in    = '0;
        cfg_req    = 1'b0;
        cfg_write  = '0;
        out_ready  = 1'b0;
        seed       = 43;
        ready_mode = 0;
        collecting = 1'b0;
        next_ch    = 0;
        for (int ch = 0; ch < n_ch; ch++) begin
            cur_kind[ch] = kind_zeros;
            seen[ch]     = 0;
        end

        // Plain values with default limits
        rows[0][0] = stim(kind_ones, 0, lim_min, lim_max);
        rows[0][1] = stim(kind_zeros, 0, lim_min, lim_max);
        rows[0][2] = stim(kind_alt, 0, lim_min, lim_max);
        rows[0][3] = stim(kind_ones, 0, lim_min, lim_max);
        // Independent shifts per channel
        rows[1][0] = stim(kind_ones, 3, lim_min, lim_max);
        rows[1][1] = stim(kind_zeros, 3, lim_min, lim_max);
        rows[1][2] = stim(kind_ones, 1, lim_min, lim_max);
        rows[1][3] = stim(kind_zeros, 0, lim_min, lim_max);
        // Clamp to +/-3000
        rows[2][0] = stim(kind_ones, 0, -3000, 3000);
        rows[2][1] = stim(kind_zeros, 0, -3000, 3000);
        rows[2][2] = stim(kind_alt, 0, -3000, 3000);
        rows[2][3] = stim(kind_ones, 2, -3000, 3000);
        // Random back-pressure on the output stream
        rows[3][0] = stim(kind_zeros, 0, lim_min, lim_max);
        rows[3][1] = stim(kind_ones, 4, lim_min, lim_max);
        rows[3][2] = stim(kind_alt, 0, lim_min, lim_max);
        rows[3][3] = stim(kind_zeros, 3, lim_min, lim_max);
        row_random[0] = 1'b0;
        row_random[1] = 1'b0;
        row_random[2] = 1'b0;
        row_random[3] = 1'b1;

        apply_reset();
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        // A long stall fills every buffer and loses the next results
        ready_mode <= 2;
        repeat (200) @(posedge clk);
        check_flag("out_valid", out_valid, 1'b1);
        check_flag("overrun", overrun, 1'b1);
        ready_mode <= 0;
        apply_reset();
        end_run();
    end

endmodule
